// File: dv/exu_props.sv
// protocol properties for the execute stage hold and multiplier writeback, bound into the top
`default_nettype none

module exu_props (
    input wire                  clk,
    input wire                  rst_n_i,
    input wire exu_pkg::issue_t issue_i,
    input wire exu_pkg::wb_t    mul_wb_o,
    input wire                  hold_o
);

    int unsigned fail_cnt = 0;

    hold_in_reset: assert property (@(posedge clk) !rst_n_i |-> !hold_o)
        else begin
            fail_cnt++;
            $error("hold_o high while reset is applied");
        end

    // first cycle out of reset
    hold_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !hold_o)
        else begin
            fail_cnt++;
            $error("hold_o high in the first cycle after reset");
        end

    mul_wb_single: assert property (@(posedge clk) disable iff (!rst_n_i)
                                    mul_wb_o.valid |=> !mul_wb_o.valid)
        else begin
            fail_cnt++;
            $error("mul_wb_o.valid high for two cycles in a row");
        end

    hold_only_mul: assert property (@(posedge clk) disable iff (!rst_n_i)
                                    hold_o |-> issue_i.valid && issue_i.op_class == exu_pkg::MUL)
        else begin
            fail_cnt++;
            $error("hold_o high without a valid mul issue");
        end

    // result cycle always ends a stall
    mul_wb_after_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
                                        mul_wb_o.valid |-> $past(hold_o))
        else begin
            fail_cnt++;
            $error("mul_wb_o.valid without hold_o in the cycle before");
        end

endmodule

`default_nettype wire

// File: dv/exu_tb.sv
// self-checking testbench for the execute stage, drives random issues and checks each response
`default_nettype none

module exu_tb;

    localparam int N_ALU   = 48;
    localparam int N_BR    = 36;
    localparam int N_JMP   = 8;
    localparam int N_MUL   = 11;
    // one extra alu issue right behind the last multiply
    localparam int N_TESTS = N_ALU + N_BR + N_JMP + N_MUL + 1;
    localparam int WDOG_T  = N_TESTS * (exu_pkg::MUL_STEPS + 4) * 4 + 200;

    typedef logic [exu_pkg::XLEN-1:0] word_t;

    logic               clk;
    logic               rst_n;
    exu_pkg::issue_t    issue;
    exu_pkg::wb_t       alu_wb;
    exu_pkg::wb_t       mul_wb;
    exu_pkg::redirect_t redirect;
    logic               hold;
    logic [31:0]        seed = 32'h17ac_c722;
    int                 errors = 0;
    int                 checks = 0;
    int                 mul_issued = 0;
    int                 mul_pulses = 0;

    exu exu_i (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .issue_i    (issue),
        .alu_wb_o   (alu_wb),
        .mul_wb_o   (mul_wb),
        .redirect_o (redirect),
        .hold_o     (hold)
    );

    bind exu exu_props props_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .issue_i  (issue_i),
        .mul_wb_o (mul_wb_o),
        .hold_o   (hold_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic exu_pkg::issue_t make_issue(exu_pkg::op_class_e cls, exu_pkg::op_e op,
                                                   logic use_imm);
        exu_pkg::issue_t iss;
        iss.valid    = 1'b1;
        iss.op_class = cls;
        iss.op       = op;
        iss.use_imm  = use_imm;
        iss.pc       = next_rand();
        iss.rs1      = next_rand();
        iss.rs2      = next_rand();
        iss.imm      = next_rand();
        iss.rd       = exu_pkg::REG_ADDR_W'(next_rand());
        return iss;
    endfunction

    function automatic logic alu_expected(exu_pkg::issue_t iss);
        if (iss.op_class == exu_pkg::BRU) begin
            return iss.op == exu_pkg::OP_JAL || iss.op == exu_pkg::OP_JALR;
        end
        return iss.op_class == exu_pkg::ALU;
    endfunction

    // reference alu, works straight from the issued fields
    function automatic word_t model_alu(exu_pkg::issue_t iss);
        word_t a;
        word_t b;
        a = iss.rs1;
        b = iss.use_imm ? iss.imm : iss.rs2;
        if (iss.op_class == exu_pkg::BRU) begin
            return iss.pc + 32'd4;
        end
        case (iss.op)
            exu_pkg::OP_ADD:   return a + b;
            exu_pkg::OP_SUB:   return a - b;
            exu_pkg::OP_SLL:   return a << b[4:0];
            exu_pkg::OP_SLT:   return word_t'($signed(a) < $signed(b));
            exu_pkg::OP_SLTU:  return word_t'(a < b);
            exu_pkg::OP_XOR:   return a ^ b;
            exu_pkg::OP_SRL:   return a >> b[4:0];
            exu_pkg::OP_SRA:   return $unsigned($signed(a) >>> b[4:0]);
            exu_pkg::OP_OR:    return a | b;
            exu_pkg::OP_AND:   return a & b;
            exu_pkg::OP_LUI:   return iss.imm;
            exu_pkg::OP_AUIPC: return iss.pc + iss.imm;
            default:           return '0;
        endcase
    endfunction

    function automatic logic model_taken(exu_pkg::issue_t iss);
        if (!iss.valid || iss.op_class != exu_pkg::BRU) begin
            return 1'b0;
        end
        case (iss.op)
            exu_pkg::OP_BEQ:  return iss.rs1 == iss.rs2;
            exu_pkg::OP_BNE:  return iss.rs1 != iss.rs2;
            exu_pkg::OP_BLT:  return $signed(iss.rs1) < $signed(iss.rs2);
            exu_pkg::OP_BLTU: return iss.rs1 < iss.rs2;
            exu_pkg::OP_BGE:  return $signed(iss.rs1) >= $signed(iss.rs2);
            exu_pkg::OP_BGEU: return iss.rs1 >= iss.rs2;
            default:          return 1'b1;
        endcase
    endfunction

    function automatic word_t model_target(exu_pkg::issue_t iss);
        if (iss.op == exu_pkg::OP_JALR) begin
            return (iss.rs1 + iss.imm) & ~32'd1;
        end
        return iss.pc + iss.imm;
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // drive one issue and follow it until it retires
    task automatic run_issue(exu_pkg::issue_t iss);
        int                          cyc;
        logic [2*exu_pkg::XLEN-1:0] prod;
        @(posedge clk);
        issue <= iss;
        @(negedge clk);
        if (iss.op_class == exu_pkg::MUL) begin
            prod = {32'd0, iss.rs1} * {32'd0, iss.rs2};
            mul_issued++;
            check_value("redirect_o.taken", '0, word_t'(redirect.taken));
            cyc = 0;
            // issue cycle plus the busy cycles, all with hold up
            while (!mul_wb.valid && cyc <= exu_pkg::MUL_STEPS + 1) begin
                check_value("hold_o", 32'd1, word_t'(hold));
                cyc++;
                @(negedge clk);
            end
            check_value("mul latency", word_t'(exu_pkg::MUL_STEPS + 1), word_t'(cyc));
            check_value("hold_o", '0, word_t'(hold));
            check_value("mul_wb_o.rd", word_t'(iss.rd), word_t'(mul_wb.rd));
            check_value("mul_wb_o.data",
                        iss.op == exu_pkg::OP_MUL ? prod[31:0] : prod[63:32], mul_wb.data);
        end else begin
            check_value("hold_o", '0, word_t'(hold));
            check_value("alu_wb_o.valid", word_t'(alu_expected(iss)), word_t'(alu_wb.valid));
            if (alu_expected(iss)) begin
                check_value("alu_wb_o.rd", word_t'(iss.rd), word_t'(alu_wb.rd));
                check_value("alu_wb_o.data", model_alu(iss), alu_wb.data);
            end
            check_value("redirect_o.taken", word_t'(model_taken(iss)), word_t'(redirect.taken));
            if (model_taken(iss)) begin
                check_value("redirect_o.target", model_target(iss), redirect.target);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && mul_wb.valid) begin
            mul_pulses++;
        end
    end

    initial begin
        exu_pkg::issue_t iss;
        int              total;
        issue <= '0;
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < N_ALU; i++) begin
            run_issue(make_issue(exu_pkg::ALU, exu_pkg::op_e'(i % 12), (i / 12) % 2 == 1));
        end
        // random, equal, signed and unsigned boundary operands
        for (int i = 0; i < N_BR; i++) begin
            iss = make_issue(exu_pkg::BRU, exu_pkg::op_e'(i % 6), 1'b0);
            case (i / 6)
                1: iss.rs2 = iss.rs1;
                2: begin
                    iss.rs1 = 32'h8000_0000;
                    iss.rs2 = 32'h7fff_ffff;
                end
                3: begin
                    iss.rs1 = 32'h7fff_ffff;
                    iss.rs2 = 32'h8000_0000;
                end
                4: begin
                    iss.rs1 = 32'h0000_0000;
                    iss.rs2 = 32'hffff_ffff;
                end
                5: begin
                    iss.rs1 = 32'hffff_ffff;
                    iss.rs2 = 32'h0000_0000;
                end
                default: ;
            endcase
            run_issue(iss);
        end
        for (int i = 0; i < N_JMP; i++) begin
            run_issue(make_issue(exu_pkg::BRU,
                                 i % 2 == 1 ? exu_pkg::OP_JALR : exu_pkg::OP_JAL, 1'b0));
        end
        // multiplies run back to back
        for (int i = 0; i < N_MUL - 2; i++) begin
            run_issue(make_issue(exu_pkg::MUL, exu_pkg::op_e'(i % 2), 1'b0));
        end
        for (int i = 0; i < 2; i++) begin
            iss = make_issue(exu_pkg::MUL, exu_pkg::op_e'(i), 1'b0);
            iss.rs1 = '1;
            iss.rs2 = '1;
            run_issue(iss);
        end
        run_issue(make_issue(exu_pkg::ALU, exu_pkg::OP_ADD, 1'b0));
        @(posedge clk);
        issue <= '0;
        repeat (2) @(negedge clk);
        check_value("mul writeback count", word_t'(mul_issued), word_t'(mul_pulses));
        total = errors + int'(exu_i.props_i.fail_cnt);
        $display("%0d checks, %0d errors, %0d property failures",
                 checks, errors, exu_i.props_i.fail_cnt);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WDOG_T);
        $display("Timeout, the run did not finish within %0d time units", WDOG_T);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: exu.f
hdl/exu_pkg.sv
hdl/exu_dispatch.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu_mul.sv
hdl/exu.sv
dv/exu_props.sv
dv/exu_tb.sv

// File: hdl/exu.sv
// execute stage top, wires dispatch to the alu, branch unit and multiplier
`default_nettype none

module exu (
    input  wire                  clk,
    input  wire                  rst_n_i,

    // from the issue stage
    input  wire exu_pkg::issue_t issue_i,

    // register writeback
    output exu_pkg::wb_t         alu_wb_o,
    output exu_pkg::wb_t         mul_wb_o,

    // to fetch control
    output exu_pkg::redirect_t   redirect_o,
    output logic                 hold_o
);

    wire exu_pkg::alu_req_t alu_req;
    wire exu_pkg::bru_req_t bru_req;
    wire exu_pkg::mul_req_t mul_req;

    exu_dispatch u_exu_dispatch (
        .issue_i   (issue_i),
        .alu_req_o (alu_req),
        .bru_req_o (bru_req),
        .mul_req_o (mul_req)
    );

    // single-cycle units
    exu_alu u_exu_alu (
        .alu_req_i (alu_req),
        .alu_wb_o  (alu_wb_o)
    );

    exu_bru u_exu_bru (
        .bru_req_i  (bru_req),
        .redirect_o (redirect_o)
    );

    // multi-cycle unit, source of the stall
    exu_mul u_exu_mul (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .mul_req_i (mul_req),
        .hold_o    (hold_o),
        .mul_wb_o  (mul_wb_o)
    );

endmodule

`default_nettype wire

// File: hdl/exu_alu.sv
// single-cycle integer alu, result is written back in the issue cycle
`default_nettype none

module exu_alu (
    input  wire exu_pkg::alu_req_t alu_req_i,
    output exu_pkg::wb_t           alu_wb_o
);

    logic [exu_pkg::XLEN-1:0]    op1;
    logic [exu_pkg::XLEN-1:0]    op2;
    logic [exu_pkg::SHAMT_W-1:0] shamt;
    logic [exu_pkg::XLEN-1:0]    result;
    logic                        lt_s;
    logic                        lt_u;

    assign op1   = alu_req_i.op1;
    assign op2   = alu_req_i.op2;
    assign shamt = op2[exu_pkg::SHAMT_W-1:0];
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;

    always_comb begin
        case (alu_req_i.op)
            // lui and auipc arrive with their operands already selected
            exu_pkg::OP_ADD,
            exu_pkg::OP_LUI,
            exu_pkg::OP_AUIPC: result = op1 + op2;
            exu_pkg::OP_SUB:   result = op1 - op2;
            exu_pkg::OP_SLL:   result = op1 << shamt;
            exu_pkg::OP_SLT:   result = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
            exu_pkg::OP_SLTU:  result = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
            exu_pkg::OP_XOR:   result = op1 ^ op2;
            exu_pkg::OP_SRL:   result = op1 >> shamt;
            exu_pkg::OP_SRA:   result = $unsigned($signed(op1) >>> shamt);
            exu_pkg::OP_OR:    result = op1 | op2;
            exu_pkg::OP_AND:   result = op1 & op2;
            default:           result = '0;
        endcase
    end

    always_comb begin
        alu_wb_o.valid = alu_req_i.req;
        alu_wb_o.rd    = alu_req_i.rd;
        alu_wb_o.data  = result;
    end

endmodule

`default_nettype wire

// File: hdl/exu_bru.sv
// branch resolution and jump target calculation, redirect is combinational
`default_nettype none

module exu_bru (
    input  wire exu_pkg::bru_req_t bru_req_i,
    output exu_pkg::redirect_t     redirect_o
);

    logic                     eq;
    logic                     lt_s;
    logic                     lt_u;
    logic                     cond;
    logic [exu_pkg::XLEN-1:0] sum;

    assign eq   = bru_req_i.cmp1 == bru_req_i.cmp2;
    assign lt_s = $signed(bru_req_i.cmp1) < $signed(bru_req_i.cmp2);
    assign lt_u = bru_req_i.cmp1 < bru_req_i.cmp2;
    assign sum  = bru_req_i.base + bru_req_i.offset;

    always_comb begin
        case (bru_req_i.op)
            exu_pkg::OP_BEQ:  cond = eq;
            exu_pkg::OP_BNE:  cond = !eq;
            exu_pkg::OP_BLT:  cond = lt_s;
            exu_pkg::OP_BLTU: cond = lt_u;
            exu_pkg::OP_BGE:  cond = !lt_s;
            exu_pkg::OP_BGEU: cond = !lt_u;
            // unconditional
            exu_pkg::OP_JAL,
            exu_pkg::OP_JALR: cond = 1'b1;
            default:          cond = 1'b0;
        endcase
    end

    always_comb begin
        redirect_o.taken = bru_req_i.req && cond;
        if (bru_req_i.op == exu_pkg::OP_JALR) begin
            // jalr target has lsb forced to zero
            redirect_o.target = {sum[exu_pkg::XLEN-1:1], 1'b0};
        end else begin
            redirect_o.target = sum;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exu_dispatch.sv
// operand router of the execute stage, turns one issued op into per-unit requests
`default_nettype none

module exu_dispatch (
    input  wire exu_pkg::issue_t issue_i,
    output exu_pkg::alu_req_t    alu_req_o,
    output exu_pkg::bru_req_t    bru_req_o,
    output exu_pkg::mul_req_t    mul_req_o
);

    logic is_alu;
    logic is_bru;
    logic is_mul;
    logic is_jump;
    logic is_jalr;
    logic is_lui;
    logic is_auipc;

    assign is_alu   = issue_i.op_class == exu_pkg::ALU;
    assign is_bru   = issue_i.op_class == exu_pkg::BRU;
    assign is_mul   = issue_i.op_class == exu_pkg::MUL;
    assign is_jalr  = is_bru && issue_i.op == exu_pkg::OP_JALR;
    assign is_jump  = is_jalr || (is_bru && issue_i.op == exu_pkg::OP_JAL);
    assign is_lui   = is_alu && issue_i.op == exu_pkg::OP_LUI;
    assign is_auipc = is_alu && issue_i.op == exu_pkg::OP_AUIPC;

    // jumps also go to the alu to write the link address
    always_comb begin
        alu_req_o.req = issue_i.valid && (is_alu || is_jump);
        alu_req_o.op  = is_jump ? exu_pkg::OP_ADD : issue_i.op;
        alu_req_o.rd  = issue_i.rd;

        if (is_jump || is_auipc) begin
            alu_req_o.op1 = issue_i.pc;
        end else if (is_lui) begin
            alu_req_o.op1 = '0;
        end else begin
            alu_req_o.op1 = issue_i.rs1;
        end

        if (is_jump) begin
            alu_req_o.op2 = exu_pkg::LINK_STEP;
        end else if (issue_i.use_imm || is_lui || is_auipc) begin
            alu_req_o.op2 = issue_i.imm;
        end else begin
            alu_req_o.op2 = issue_i.rs2;
        end
    end

    always_comb begin
        bru_req_o.req    = issue_i.valid && is_bru;
        bru_req_o.op     = issue_i.op;
        bru_req_o.cmp1   = issue_i.rs1;
        bru_req_o.cmp2   = issue_i.rs2;
        // jalr is register relative, everything else pc relative
        bru_req_o.base   = is_jalr ? issue_i.rs1 : issue_i.pc;
        bru_req_o.offset = issue_i.imm;
    end

    always_comb begin
        mul_req_o.req          = issue_i.valid && is_mul;
        mul_req_o.op           = issue_i.op;
        mul_req_o.multiplicand = issue_i.rs1;
        mul_req_o.multiplier   = issue_i.rs2;
        mul_req_o.rd           = issue_i.rd;
    end

endmodule

`default_nettype wire

// File: hdl/exu_mul.sv
// iterative unsigned multiplier, holds the issuing stage until its result cycle
`default_nettype none

module exu_mul (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire exu_pkg::mul_req_t mul_req_i,
    output logic                   hold_o,
    output exu_pkg::wb_t           mul_wb_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUSY,
        S_RESULT
    } state_e;

    state_e                             state_q;
    logic [exu_pkg::MUL_CNT_W-1:0]      cnt_q;
    logic [2*exu_pkg::XLEN-1:0]         acc_q;
    logic [2*exu_pkg::XLEN-1:0]         mcand_q;
    logic [exu_pkg::XLEN-1:0]           mplier_q;
    exu_pkg::op_e                       op_q;
    logic [exu_pkg::REG_ADDR_W-1:0]     rd_q;
    logic                               accept;

    assign accept = state_q == S_IDLE && mul_req_i.req;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (mul_req_i.req) begin
                        state_q <= S_BUSY;
                        cnt_q   <= '0;
                    end
                end
                S_BUSY: begin
                    if (cnt_q == exu_pkg::MUL_LAST_STEP) begin
                        state_q <= S_RESULT;
                    end
                    cnt_q <= cnt_q + 1'b1;
                end
                // upstream moves on after this cycle
                S_RESULT: state_q <= S_IDLE;
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    // one multiplier bit per busy cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_q    <= '0;
            mcand_q  <= {{exu_pkg::XLEN{1'b0}}, mul_req_i.multiplicand};
            mplier_q <= mul_req_i.multiplier;
            op_q     <= mul_req_i.op;
            rd_q     <= mul_req_i.rd;
        end else if (state_q == S_BUSY) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

    assign hold_o = mul_req_i.req && state_q != S_RESULT;

    always_comb begin
        mul_wb_o.valid = state_q == S_RESULT;
        mul_wb_o.rd    = rd_q;
        case (op_q)
            exu_pkg::OP_MUL:   mul_wb_o.data = acc_q[exu_pkg::XLEN-1:0];
            exu_pkg::OP_MULHU: mul_wb_o.data = acc_q[2*exu_pkg::XLEN-1:exu_pkg::XLEN];
            default:           mul_wb_o.data = acc_q[exu_pkg::XLEN-1:0];
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/exu_pkg.sv
// shared widths, op codes and bundles for the execute stage, referenced by scoped name
`default_nettype none

package exu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(XLEN);
    localparam int MUL_STEPS  = XLEN;
    localparam int MUL_CNT_W  = $clog2(MUL_STEPS);

    localparam logic [MUL_CNT_W-1:0] MUL_LAST_STEP = MUL_CNT_W'(MUL_STEPS - 1);
    // link address is pc plus one instruction
    localparam logic [XLEN-1:0] LINK_STEP = 'd4;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        BRU = 2'd1,
        MUL = 2'd2
    } op_class_e;

    // op codes are only unique within a class
    typedef logic [3:0] op_e;

    localparam op_e OP_ADD   = 4'd0;
    localparam op_e OP_SUB   = 4'd1;
    localparam op_e OP_SLL   = 4'd2;
    localparam op_e OP_SLT   = 4'd3;
    localparam op_e OP_SLTU  = 4'd4;
    localparam op_e OP_XOR   = 4'd5;
    localparam op_e OP_SRL   = 4'd6;
    localparam op_e OP_SRA   = 4'd7;
    localparam op_e OP_OR    = 4'd8;
    localparam op_e OP_AND   = 4'd9;
    localparam op_e OP_LUI   = 4'd10;
    localparam op_e OP_AUIPC = 4'd11;

    localparam op_e OP_BEQ   = 4'd0;
    localparam op_e OP_BNE   = 4'd1;
    localparam op_e OP_BLT   = 4'd2;
    localparam op_e OP_BLTU  = 4'd3;
    localparam op_e OP_BGE   = 4'd4;
    localparam op_e OP_BGEU  = 4'd5;
    localparam op_e OP_JAL   = 4'd6;
    localparam op_e OP_JALR  = 4'd7;

    localparam op_e OP_MUL   = 4'd0;
    localparam op_e OP_MULHU = 4'd1;

    typedef struct packed {
        logic                  valid;
        op_class_e             op_class;
        op_e                   op;
        logic                  use_imm;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1;
        logic [XLEN-1:0]       rs2;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
    } issue_t;

    typedef struct packed {
        logic                  req;
        op_e                   op;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [REG_ADDR_W-1:0] rd;
    } alu_req_t;

    typedef struct packed {
        logic            req;
        op_e             op;
        logic [XLEN-1:0] cmp1;
        logic [XLEN-1:0] cmp2;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] offset;
    } bru_req_t;

    typedef struct packed {
        logic                  req;
        op_e                   op;
        logic [XLEN-1:0]       multiplicand;
        logic [XLEN-1:0]       multiplier;
        logic [REG_ADDR_W-1:0] rd;
    } mul_req_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module exu_tb -f exu.f -o exu_sim || exit 1
./obj_dir/exu_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
